// ==== logic/icache_pkg.sv ====
// instruction cache shared definitions
// geometry localparams, vector typedefs and the controller state enum

package icache_pkg;

  ////////////////////////////////////////////////////////////////////
  // geometry
  ////////////////////////////////////////////////////////////////////

  // fetch and refill addresses are physical
  localparam int ADDR_WIDTH    = 32;
  localparam int FETCH_WIDTH   = 32;
  // one refill beat carries a whole line
  localparam int LINE_WIDTH    = 128;
  localparam int NUM_WAYS      = 4;
  localparam int NUM_SETS      = 16;
  // byte offset inside a line, bits [1:0] never select anything
  localparam int OFFSET_WIDTH  = 4;
  localparam int INDEX_WIDTH   = 4;
  // whatever is left above index and offset
  localparam int TAG_WIDTH     = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
  localparam int WAY_IDX_WIDTH = 2;
  localparam int AGE_WIDTH     = 2;

  ////////////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////////////

  typedef logic [ADDR_WIDTH-1:0]    addr_t;
  typedef logic [FETCH_WIDTH-1:0]   word_t;
  typedef logic [LINE_WIDTH-1:0]    line_t;
  typedef logic [TAG_WIDTH-1:0]     tag_t;
  typedef logic [INDEX_WIDTH-1:0]   index_t;
  typedef logic [OFFSET_WIDTH-1:0]  offset_t;
  // one bit per way
  typedef logic [NUM_WAYS-1:0]      way_oh_t;
  typedef logic [WAY_IDX_WIDTH-1:0] way_idx_t;
  // 0 is most recent, NUM_WAYS-1 is the replacement candidate
  typedef logic [AGE_WIDTH-1:0]     age_t;

  // controller states
  typedef enum logic [1:0] {
    FLUSH,
    IDLE,
    READ,
    MISS
  } state_e;

endpackage

// ==== logic/icache_arrays.sv ====
// instruction cache storage
// per-way tag, valid and line arrays with synchronous read,
// tag compare and word select from the hitting way

`timescale 1ns/1ps

module icache_arrays import icache_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    rden_i,
  input  logic    wren_i,
  input  logic    clear_i,
  input  index_t  index_i,
  input  offset_t offset_i,
  input  tag_t    tag_i,
  input  way_oh_t way_oh_i,
  input  line_t   wdata_i,
  output logic    hit_o,
  output way_oh_t hit_oh_o,
  output way_oh_t valid_o,
  output word_t   word_o
);

  tag_t    tag_mem  [NUM_WAYS][NUM_SETS];
  line_t   data_mem [NUM_WAYS][NUM_SETS];
  // valid bits are flops so a flush and reset can clear them
  way_oh_t valid_q  [NUM_SETS];

  // read port registers
  tag_t    rd_tag   [NUM_WAYS];
  line_t   rd_line  [NUM_WAYS];
  way_oh_t rd_valid_q;
  offset_t rd_offset_q;
  // read data is only compared the cycle after a read
  logic    rd_en_q;
  way_oh_t hit_oh;

  ////////////////////////////////////////////////////////////////////
  // valid bits
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        valid_q[s] <= '0;
      end
      rd_valid_q <= '0;
      rd_en_q    <= 1'b0;
    end else begin
      rd_en_q <= rden_i;
      // clear drops all ways of the set
      if (clear_i) begin
        valid_q[index_i] <= '0;
      end else if (wren_i) begin
        valid_q[index_i] <= valid_q[index_i] | way_oh_i;
      end
      if (rden_i) begin
        rd_valid_q <= valid_q[index_i];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // tag and line storage
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (wren_i && way_oh_i[w]) begin
        tag_mem[w][index_i]  <= tag_i;
        data_mem[w][index_i] <= wdata_i;
      end
      if (rden_i) begin
        rd_tag[w]  <= tag_mem[w][index_i];
        rd_line[w] <= data_mem[w][index_i];
      end
    end
    if (rden_i) begin
      rd_offset_q <= offset_i;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // compare and select
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    word_o = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      hit_oh[w] = rd_en_q & rd_valid_q[w] & (rd_tag[w] == tag_i);
      // one-hot hit, so an OR works as the way mux
      if (hit_oh[w]) begin
        word_o = word_o |
                 rd_line[w][{rd_offset_q[OFFSET_WIDTH-1:2], 5'b00000} +: FETCH_WIDTH];
      end
    end
  end

  assign hit_oh_o = hit_oh;
  assign hit_o    = |hit_oh;
  assign valid_o  = rd_valid_q;

endmodule

// ==== logic/icache_lru.sv ====
// instruction cache replacement
// per-set age counters, aging on hit and fill, reset of ages on clear,
// victim choice preferring an empty way

`timescale 1ns/1ps

module icache_lru import icache_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  index_t  index_i,
  input  logic    hit_i,
  input  way_oh_t hit_oh_i,
  input  logic    fill_i,
  input  logic    clear_i,
  input  way_oh_t fill_oh_i,
  input  way_oh_t valid_i,
  output way_oh_t victim_oh_o
);

  age_t     ages_q [NUM_SETS][NUM_WAYS];
  // set of the lookup whose compare result arrives this cycle
  index_t   lookup_idx_q;
  logic     inv_found;
  way_idx_t inv_way;
  way_idx_t lru_way;

  // saturating increment
  function automatic age_t age_inc(age_t age);
    return (age == '1) ? age : age + 1'b1;
  endfunction

  always_ff @(posedge clk_i) begin
    lookup_idx_q <= index_i;
  end

  ////////////////////////////////////////////////////////////////////
  // age update
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < NUM_SETS; s++) begin
        for (int w = 0; w < NUM_WAYS; w++) begin
          ages_q[s][w] <= '0;
        end
      end
    end else if (clear_i) begin
      // distinct ages after a flush
      for (int w = 0; w < NUM_WAYS; w++) begin
        ages_q[index_i][w] <= age_t'(w);
      end
    end else if (fill_i) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        ages_q[index_i][w] <= fill_oh_i[w] ? '0 : age_inc(ages_q[index_i][w]);
      end
    end else if (hit_i) begin
      // hit belongs to the set read one cycle earlier
      for (int w = 0; w < NUM_WAYS; w++) begin
        ages_q[lookup_idx_q][w] <= hit_oh_i[w] ? '0 : age_inc(ages_q[lookup_idx_q][w]);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // victim choice
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    inv_found = 1'b0;
    inv_way   = '0;
    // way 0 if no way has reached the top age
    lru_way   = '0;
    // walk downwards so the lowest matching way wins
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      if (!valid_i[w]) begin
        inv_found = 1'b1;
        inv_way   = way_idx_t'(w);
      end
      if (ages_q[lookup_idx_q][w] == age_t'(NUM_WAYS - 1)) begin
        lru_way = way_idx_t'(w);
      end
    end
  end

  assign victim_oh_o = way_oh_t'(1) << (inv_found ? inv_way : lru_way);

endmodule

// ==== logic/icache_ctrl.sv ====
// instruction cache controller
// fetch / miss / flush FSM, held request address, flush counter,
// array control and output word selection

`timescale 1ns/1ps

module icache_ctrl import icache_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    en_i,
  input  logic    flush_i,
  input  logic    fetch_req_i,
  input  addr_t   fetch_addr_i,
  output logic    fetch_ready_o,
  output logic    fetch_valid_o,
  output word_t   fetch_data_o,
  output logic    miss_o,
  output logic    mem_req_o,
  output addr_t   mem_addr_o,
  output logic    mem_nc_o,
  input  logic    mem_ack_i,
  input  logic    mem_rtrn_vld_i,
  input  line_t   mem_rtrn_data_i,
  output logic    arr_rden_o,
  output logic    arr_wren_o,
  output logic    arr_clear_o,
  output index_t  arr_index_o,
  output offset_t arr_offset_o,
  output tag_t    arr_tag_o,
  output way_oh_t arr_way_oh_o,
  input  logic    arr_hit_i,
  input  word_t   arr_word_i,
  input  way_oh_t victim_oh_i
);

  state_e  state_d, state_q;
  logic    cache_en_d, cache_en_q;
  // pending flush, held until the FSM is back in IDLE
  logic    flush_d, flush_q;
  logic    flush_take;
  logic    flush_done;
  index_t  flush_cnt_d, flush_cnt_q;
  logic    accept;
  tag_t    tag_d, tag_q;
  index_t  index_d, index_q;
  offset_t offset_d, offset_q;
  way_oh_t victim_q;
  word_t   rtrn_word;

  ////////////////////////////////////////////////////////////////////
  // request address and array addressing
  ////////////////////////////////////////////////////////////////////

  assign accept   = fetch_req_i & fetch_ready_o;

  // split the fetch address on acceptance, hold it otherwise
  assign tag_d    = accept ? fetch_addr_i[ADDR_WIDTH-1 -: TAG_WIDTH] : tag_q;
  assign index_d  = accept ? fetch_addr_i[OFFSET_WIDTH +: INDEX_WIDTH] : index_q;
  assign offset_d = accept ? fetch_addr_i[OFFSET_WIDTH-1:0] : offset_q;

  // flush walks the sets, otherwise the lookup / fill set
  assign arr_index_o  = (state_q == FLUSH) ? flush_cnt_q : index_d;
  assign arr_offset_o = offset_d;
  // held tag serves the compare in READ and the tag write in MISS
  assign arr_tag_o    = tag_q;
  assign arr_way_oh_o = victim_q;
  // no lookup while disabled, the request goes out as non-cacheable
  assign arr_rden_o   = accept & cache_en_q;

  // line-aligned refill address
  assign mem_addr_o = {tag_q, index_q, {OFFSET_WIDTH{1'b0}}};
  assign mem_nc_o   = ~cache_en_q;

  // word of the returned line, bits [1:0] of the offset are ignored
  assign rtrn_word    = mem_rtrn_data_i[{offset_q[OFFSET_WIDTH-1:2], 5'b00000} +: FETCH_WIDTH];
  assign fetch_data_o = (state_q == READ) ? arr_word_i : rtrn_word;

  ////////////////////////////////////////////////////////////////////
  // flush handling
  ////////////////////////////////////////////////////////////////////

  // a flush request, or enabling a disabled cache, both need a full clear
  assign flush_take  = flush_q | flush_i | (en_i & ~cache_en_q);
  assign flush_done  = (flush_cnt_q == index_t'(NUM_SETS - 1));
  assign flush_cnt_d = (state_q != FLUSH) ? flush_cnt_q :
                       flush_done         ? '0          :
                                            flush_cnt_q + 1'b1;

  ////////////////////////////////////////////////////////////////////
  // main FSM
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    // turning off is immediate, turning on goes through FLUSH
    cache_en_d    = cache_en_q & en_i;
    flush_d       = flush_q | flush_i;
    fetch_ready_o = 1'b0;
    fetch_valid_o = 1'b0;
    mem_req_o     = 1'b0;
    miss_o        = 1'b0;
    arr_wren_o    = 1'b0;
    arr_clear_o   = 1'b0;

    unique case (state_q)
      // clear one set per cycle
      FLUSH: begin
        arr_clear_o = 1'b1;
        if (flush_done) begin
          state_d    = IDLE;
          flush_d    = 1'b0;
          cache_en_d = en_i;
        end
      end
      // wait for a request, pending flushes go first
      IDLE: begin
        if (flush_take) begin
          state_d = FLUSH;
        end else begin
          fetch_ready_o = 1'b1;
          if (fetch_req_i) begin
            state_d = READ;
          end
        end
      end
      // compare the lookup, on a miss hold the refill request until ack
      READ: begin
        if (cache_en_q && arr_hit_i) begin
          fetch_valid_o = 1'b1;
          state_d       = IDLE;
          // next request can overlap the result cycle
          if (!flush_take) begin
            fetch_ready_o = 1'b1;
            if (fetch_req_i) begin
              state_d = READ;
            end
          end
        end else begin
          mem_req_o = 1'b1;
          if (mem_ack_i) begin
            // only real misses count, nc traffic does not
            miss_o  = cache_en_q;
            state_d = MISS;
          end
        end
      end
      // line comes back, answer the fetch and fill if cacheable
      MISS: begin
        if (mem_rtrn_vld_i) begin
          fetch_valid_o = 1'b1;
          arr_wren_o    = cache_en_q;
          state_d       = IDLE;
        end
      end
      default: begin
        state_d = FLUSH;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      cache_en_q  <= 1'b0;
      flush_q     <= 1'b0;
      flush_cnt_q <= '0;
    end else begin
      state_q     <= state_d;
      cache_en_q  <= cache_en_d;
      flush_q     <= flush_d;
      flush_cnt_q <= flush_cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    tag_q    <= tag_d;
    index_q  <= index_d;
    offset_q <= offset_d;
    // victim is stable while READ waits for the ack
    if (state_q == READ) begin
      victim_q <= victim_oh_i;
    end
  end

endmodule

// ==== logic/icache_top.sv ====
// instruction cache top level
// connects the controller, the storage arrays and the replacement logic

`timescale 1ns/1ps

module icache_top import icache_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  en_i,
  input  logic  flush_i,
  input  logic  fetch_req_i,
  input  addr_t fetch_addr_i,
  output logic  fetch_ready_o,
  output logic  fetch_valid_o,
  output word_t fetch_data_o,
  output logic  miss_o,
  output logic  mem_req_o,
  output addr_t mem_addr_o,
  output logic  mem_nc_o,
  input  logic  mem_ack_i,
  input  logic  mem_rtrn_vld_i,
  input  line_t mem_rtrn_data_i
);

  // controller to arrays
  logic    arr_rden;
  logic    arr_wren;
  logic    arr_clear;
  index_t  arr_index;
  offset_t arr_offset;
  tag_t    arr_tag;
  way_oh_t arr_way_oh;
  // arrays back to controller and replacement
  logic    arr_hit;
  way_oh_t arr_hit_oh;
  way_oh_t arr_valid;
  word_t   arr_word;
  way_oh_t victim_oh;

  icache_ctrl icache_ctrl_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .en_i            (en_i),
    .flush_i         (flush_i),
    .fetch_req_i     (fetch_req_i),
    .fetch_addr_i    (fetch_addr_i),
    .fetch_ready_o   (fetch_ready_o),
    .fetch_valid_o   (fetch_valid_o),
    .fetch_data_o    (fetch_data_o),
    .miss_o          (miss_o),
    .mem_req_o       (mem_req_o),
    .mem_addr_o      (mem_addr_o),
    .mem_nc_o        (mem_nc_o),
    .mem_ack_i       (mem_ack_i),
    .mem_rtrn_vld_i  (mem_rtrn_vld_i),
    .mem_rtrn_data_i (mem_rtrn_data_i),
    .arr_rden_o      (arr_rden),
    .arr_wren_o      (arr_wren),
    .arr_clear_o     (arr_clear),
    .arr_index_o     (arr_index),
    .arr_offset_o    (arr_offset),
    .arr_tag_o       (arr_tag),
    .arr_way_oh_o    (arr_way_oh),
    .arr_hit_i       (arr_hit),
    .arr_word_i      (arr_word),
    .victim_oh_i     (victim_oh)
  );

  // refill data is written straight from the return bus
  icache_arrays icache_arrays_inst (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .rden_i   (arr_rden),
    .wren_i   (arr_wren),
    .clear_i  (arr_clear),
    .index_i  (arr_index),
    .offset_i (arr_offset),
    .tag_i    (arr_tag),
    .way_oh_i (arr_way_oh),
    .wdata_i  (mem_rtrn_data_i),
    .hit_o    (arr_hit),
    .hit_oh_o (arr_hit_oh),
    .valid_o  (arr_valid),
    .word_o   (arr_word)
  );

  // fills and clears use the same set and way as the array write
  icache_lru icache_lru_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .index_i     (arr_index),
    .hit_i       (arr_hit),
    .hit_oh_i    (arr_hit_oh),
    .fill_i      (arr_wren),
    .clear_i     (arr_clear),
    .fill_oh_i   (arr_way_oh),
    .valid_i     (arr_valid),
    .victim_oh_o (victim_oh)
  );

endmodule

// ==== testbench/icache_properties.sv ====
// controller checks bound into icache_ctrl
// refill request hold, one-hot or empty hit way, no ready in FLUSH,
// no fetch result without an accepted request

`timescale 1ns/1ps

module icache_properties import icache_pkg::*; (
  input logic    clk_i,
  input logic    rst_ni,
  input state_e  state_i,
  input logic    fetch_req_i,
  input logic    fetch_ready_i,
  input logic    fetch_valid_i,
  input logic    mem_req_i,
  input logic    mem_ack_i,
  input way_oh_t hit_oh_i
);

  // failure count, read by the testbench summary
  int   prop_errors = 0;
  // a request was accepted and its result has not been seen yet
  logic pending_q;

  // an accept in the result cycle keeps the next request outstanding
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
    end else if (fetch_req_i && fetch_ready_i) begin
      pending_q <= 1'b1;
    end else if (fetch_valid_i) begin
      pending_q <= 1'b0;
    end
  end

  req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
      mem_req_i && !mem_ack_i |=> mem_req_i)
    else begin
      prop_errors++;
      $error("refill request dropped before acknowledge");
    end

  // a line sits in at most one way of its set
  hit_way_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
      $onehot0(hit_oh_i))
    else begin
      prop_errors++;
      $error("hit way vector has more than one bit set");
    end

  no_ready_in_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
      state_i == FLUSH |-> !fetch_ready_i)
    else begin
      prop_errors++;
      $error("fetch ready raised during flush");
    end

  valid_after_accept: assert property (@(posedge clk_i) disable iff (!rst_ni)
      fetch_valid_i |-> pending_q)
    else begin
      prop_errors++;
      $error("fetch valid without an accepted request");
    end

endmodule

bind icache_ctrl icache_properties icache_properties_inst (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .state_i       (state_q),
  .fetch_req_i   (fetch_req_i),
  .fetch_ready_i (fetch_ready_o),
  .fetch_valid_i (fetch_valid_o),
  .mem_req_i     (mem_req_o),
  .mem_ack_i     (mem_ack_i),
  .hit_oh_i      (icache_arrays_inst.hit_oh_o)
);

// ==== testbench/tb_icache.sv ====
// instruction cache testbench
// clock and reset, refill memory model with LFSR delays,
// directed tests, timeout and summary

`timescale 1ns/1ps

module tb_icache import icache_pkg::*; ();

  // tests run for a few hundred cycles, ten times that as the ceiling
  localparam int          TIMEOUT_CYCLES = 4000;
  localparam logic [15:0] LFSR_SEED      = 16'd10690;
  localparam word_t       DATA_XOR       = 32'hA5A5_0000;
  // set 5, one tag step per way
  localparam addr_t       LRU_BASE       = 32'h0001_0050;

  typedef enum logic [1:0] {
    MEM_IDLE,
    MEM_WAIT,
    MEM_ACK,
    MEM_RTRN
  } mem_phase_e;

  logic  clk_i;
  logic  rst_ni;
  logic  en_i;
  logic  flush_i;
  logic  fetch_req_i;
  addr_t fetch_addr_i;
  logic  fetch_ready_o;
  logic  fetch_valid_o;
  word_t fetch_data_o;
  logic  miss_o;
  logic  mem_req_o;
  addr_t mem_addr_o;
  logic  mem_nc_o;
  logic  mem_ack_i;
  logic  mem_rtrn_vld_i;
  line_t mem_rtrn_data_i;

  // memory model state and bookkeeping
  mem_phase_e  mem_phase;
  logic [15:0] lfsr_q;
  int          wait_cnt;
  addr_t       rtrn_addr;
  int          req_count;
  addr_t       last_req_addr;
  logic        last_req_nc;
  int          miss_count;
  int          errors;
  int          tests_failed;
  int          cycle_count;

  icache_top icache_top_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////
  // reference model helpers
  ////////////////////////////////////////////////////////////////////

  // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // every memory word holds its own byte address xor a constant
  function automatic word_t expected_word(addr_t addr);
    return {addr[ADDR_WIDTH-1:2], 2'b00} ^ DATA_XOR;
  endfunction

  function automatic line_t line_for(addr_t line_addr);
    line_t line;
    for (int i = 0; i < LINE_WIDTH / FETCH_WIDTH; i++) begin
      line[i*FETCH_WIDTH +: FETCH_WIDTH] = expected_word(line_addr + addr_t'(4 * i));
    end
    return line;
  endfunction

  task automatic report_error(string msg);
    errors++;
    $display("** Error @ %0t: %s", $time, msg);
  endtask

  task automatic end_test(string name, int errs_before);
    if (errors == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: FAILED, %0d errors", name, errors - errs_before);
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // refill memory
  ////////////////////////////////////////////////////////////////////

  // ack after 0 to 3 random cycles, line returns 2 cycles after the ack
  initial begin : mem_model
    logic [1:0] delay;
    mem_ack_i       <= 1'b0;
    mem_rtrn_vld_i  <= 1'b0;
    mem_rtrn_data_i <= '0;
    lfsr_q    = LFSR_SEED;
    mem_phase = MEM_IDLE;
    req_count = 0;
    forever begin
      @(posedge clk_i);
      mem_rtrn_vld_i <= 1'b0;
      case (mem_phase)
        MEM_IDLE: begin
          if (mem_req_o) begin
            // two bits, one LFSR step each
            lfsr_q   = lfsr_next(lfsr_q);
            delay[0] = lfsr_q[0];
            lfsr_q   = lfsr_next(lfsr_q);
            delay[1] = lfsr_q[0];
            if (delay == 2'd0) begin
              mem_ack_i <= 1'b1;
              mem_phase = MEM_ACK;
            end else begin
              wait_cnt  = int'(delay) - 1;
              mem_phase = MEM_WAIT;
            end
          end
        end
        MEM_WAIT: begin
          if (wait_cnt == 0) begin
            mem_ack_i <= 1'b1;
            mem_phase = MEM_ACK;
          end else begin
            wait_cnt--;
          end
        end
        // handshake completes on this edge
        MEM_ACK: begin
          mem_ack_i <= 1'b0;
          req_count++;
          last_req_addr = mem_addr_o;
          last_req_nc   = mem_nc_o;
          rtrn_addr     = mem_addr_o;
          mem_phase     = MEM_RTRN;
        end
        default: begin
          mem_rtrn_vld_i  <= 1'b1;
          mem_rtrn_data_i <= line_for(rtrn_addr);
          mem_phase = MEM_IDLE;
        end
      endcase
    end
  end

  initial begin
    miss_count = 0;
    forever begin
      @(posedge clk_i);
      if (miss_o) begin
        miss_count++;
      end
    end
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("timeout after %0d cycles, a fetch or refill never completed", cycle_count);
    $display("Regression failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////
  // fetch helpers
  ////////////////////////////////////////////////////////////////////

  // lat counts cycles from acceptance to the result
  task automatic fetch_word(input addr_t addr, output word_t data, output int lat);
    @(posedge clk_i);
    fetch_req_i  <= 1'b1;
    fetch_addr_i <= addr;
    do begin
      @(posedge clk_i);
    end while (!fetch_ready_o);
    fetch_req_i <= 1'b0;
    lat = 0;
    do begin
      @(posedge clk_i);
      lat++;
    end while (!fetch_valid_o);
    data = fetch_data_o;
  endtask

  task automatic fetch_checked(input addr_t addr, output int lat);
    word_t data;
    fetch_word(addr, data, lat);
    assert (data == expected_word(addr))
      else report_error($sformatf("addr %h: data %h, expected %h", addr, data,
                                  expected_word(addr)));
  endtask

  ////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////

  // enabling flushes first, then the first fetch has to refill
  task automatic first_fetch_after_enable();
    int errs;
    int reqs;
    int misses;
    int lat;
    errs   = errors;
    reqs   = req_count;
    misses = miss_count;
    en_i <= 1'b1;
    fetch_checked(32'h0000_1008, lat);
    assert (req_count == reqs + 1) else report_error("expected exactly one refill request");
    assert (last_req_addr == 32'h0000_1000)
      else report_error($sformatf("refill address %h, expected 00001000", last_req_addr));
    assert (!last_req_nc) else report_error("refill marked non-cacheable while enabled");
    assert (miss_count == misses + 1) else report_error("expected one miss pulse");
    end_test("first fetch after enable", errs);
  endtask

  task automatic same_line_hits();
    int errs;
    int reqs;
    int lat;
    errs = errors;
    reqs = req_count;
    fetch_checked(32'h0000_1004, lat);
    assert (lat == 1) else report_error($sformatf("hit latency %0d, expected 1", lat));
    // pair of requests, the second one overlaps the first result
    @(posedge clk_i);
    fetch_req_i  <= 1'b1;
    fetch_addr_i <= 32'h0000_1008;
    do begin
      @(posedge clk_i);
    end while (!fetch_ready_o);
    fetch_addr_i <= 32'h0000_100C;
    @(posedge clk_i);
    assert (fetch_valid_o && fetch_data_o == expected_word(32'h0000_1008))
      else report_error("first of pair not returned one cycle after acceptance");
    assert (fetch_ready_o) else report_error("second request not accepted in result cycle");
    fetch_req_i <= 1'b0;
    @(posedge clk_i);
    assert (fetch_valid_o && fetch_data_o == expected_word(32'h0000_100C))
      else report_error("second of pair not returned one cycle after acceptance");
    assert (req_count == reqs) else report_error("hit raised a refill request");
    end_test("same line hits", errs);
  endtask

  // A..D fill set 5, A is touched, E then evicts B
  task automatic lru_replacement();
    int errs;
    int reqs;
    int lat;
    errs = errors;
    for (int n = 0; n < 4; n++) begin
      fetch_checked(addr_t'(LRU_BASE + 32'h100 * n), lat);
    end
    fetch_checked(LRU_BASE, lat);
    assert (lat == 1) else report_error("tag A not resident before the fifth tag");
    fetch_checked(addr_t'(LRU_BASE + 32'h400), lat);
    reqs = req_count;
    fetch_checked(LRU_BASE, lat);
    assert (req_count == reqs) else report_error("recently used tag A was evicted");
    fetch_checked(addr_t'(LRU_BASE + 32'h100), lat);
    assert (req_count == reqs + 1) else report_error("oldest tag B was not evicted");
    end_test("lru replacement", errs);
  endtask

  task automatic flush_clears_lines();
    int errs;
    int reqs;
    int lat;
    errs = errors;
    fetch_checked(32'h0000_1008, lat);
    assert (lat == 1) else report_error("line not resident before the flush");
    @(posedge clk_i);
    flush_i <= 1'b1;
    @(posedge clk_i);
    flush_i <= 1'b0;
    for (int i = 0; i < NUM_SETS; i++) begin
      assert (!fetch_ready_o) else report_error("fetch ready during the flush");
      @(posedge clk_i);
    end
    reqs = req_count;
    fetch_checked(32'h0000_1008, lat);
    assert (req_count == reqs + 1) else report_error("flushed line still hit");
    end_test("flush clears lines", errs);
  endtask

  task automatic disabled_cache_bypass();
    int errs;
    int reqs;
    int misses;
    int lat;
    errs = errors;
    en_i <= 1'b0;
    repeat (2) @(posedge clk_i);
    misses = miss_count;
    // same address twice, both must go to memory
    for (int i = 0; i < 2; i++) begin
      reqs = req_count;
      fetch_checked(32'h0000_1004, lat);
      assert (req_count == reqs + 1) else report_error("disabled fetch did not go to memory");
      assert (last_req_nc) else report_error("disabled fetch not marked non-cacheable");
    end
    assert (miss_count == misses) else report_error("miss pulse while disabled");
    end_test("disabled cache bypass", errs);
  endtask

  // 8 lines in 8 sets, low address bits vary too
  task automatic random_delay_stream();
    int    errs;
    int    lat;
    int    line_no;
    addr_t addr;
    errs = errors;
    en_i <= 1'b1;
    for (int i = 0; i < 40; i++) begin
      line_no = (i * 5) % 8;
      addr    = addr_t'(32'h0002_0000 + 32'h110 * line_no + 4 * (i % 4) + (i % 3));
      fetch_checked(addr, lat);
    end
    end_test("random delay stream", errs);
  endtask

  ////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////

  initial begin
    int prop_errors;
    rst_ni       <= 1'b0;
    en_i         <= 1'b0;
    flush_i      <= 1'b0;
    fetch_req_i  <= 1'b0;
    fetch_addr_i <= '0;
    errors       = 0;
    tests_failed = 0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;
    first_fetch_after_enable();
    same_line_hits();
    lru_replacement();
    flush_clears_lines();
    disabled_cache_bypass();
    random_delay_stream();
    prop_errors = icache_top_inst.icache_ctrl_inst.icache_properties_inst.prop_errors;
    $display("summary: 6 tests, %0d failed, %0d check errors, %0d property errors",
             tests_failed, errors, prop_errors);
    if (errors == 0 && prop_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
logic/icache_pkg.sv
logic/icache_arrays.sv
logic/icache_lru.sv
logic/icache_ctrl.sv
logic/icache_top.sv
testbench/icache_properties.sv
testbench/tb_icache.sv

// ==== run.sh ====
#!/bin/sh
# build and run the instruction cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_icache \
  -f compile.f \
  -Mdir obj_dir -o tb_icache_sim

# pass or fail comes from the log, not from the simulator status
./obj_dir/tb_icache_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Regression passed" sim.log; then
  exit 0
else
  echo "simulation did not report a pass" >&2
  exit 1
fi
